//--- Makefile
# Verilator build and run of the fetch front end testbench

OBJ = obj_dir

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing -f src.f --top-module fetch_tb -Mdir $(OBJ) -o fetch_sim
	@out=$$(./$(OBJ)/fetch_sim); echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ)

//--- bench/fetch_stimulus.txt
// one test per line, all fields hex
// redirect  target  instructions  misaligned_exc  mem_requests_for_target_lines
0 00001000 10 0 4   // from the reset pc, no redirect
1 00001000 10 0 0   // same lines again, all hits
1 00002080 4  0 1   // line A in set 8
1 00002480 4  0 1   // line B, same set
1 00002080 4  0 0   // A hit, B now least recent
1 00002880 4  0 1   // line C replaces B
1 00002080 4  0 0   // A still there
1 00002480 4  0 1   // B was evicted
1 00003100 4  0 1   // leaves a miss on 3110 in flight
1 00005200 4  0 1   // redirect over that miss
1 0000600a 1  1 0   // misaligned target
1 00007004 5  0 2   // upper word target, lane 0 alone first

//--- bench/fetch_tb.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

module fetch_tb import fetch_pkg::*; ();

    localparam int FIELDS    = 5;     // redirect, target, count, exception, memory requests
    localparam int MAX_TESTS = 32;

    logic        clk;
    logic        reset;
    logic        redirect;
    fetch_addr_t redirect_pc;
    logic        mem_req;
    fetch_addr_t mem_addr;
    logic        mem_rdy;
    logic        ret_valid;
    logic        ret_last;
    instr_t      ret_data;
    logic        lane0_valid;
    instr_t      lane0_instr;
    logic        lane1_valid;
    instr_t      lane1_instr;
    fetch_addr_t out_pc;
    fetch_exc_t  out_exc;

    logic [31:0] stim [FIELDS*MAX_TESTS];
    fetch_addr_t req_log [$];   // line addresses in handshake order
    int          num_tests;
    int          checks;
    int          errors;
    int          cycles;
    int          limit;

    fetch_top dut (
        .clk         (clk),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_rdy     (mem_rdy),
        .ret_valid   (ret_valid),
        .ret_last    (ret_last),
        .ret_data    (ret_data),
        .lane0_valid (lane0_valid),
        .lane0_instr (lane0_instr),
        .lane1_valid (lane1_valid),
        .lane1_instr (lane1_instr),
        .out_pc      (out_pc),
        .out_exc     (out_exc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // memory contents: the address with its upper half inverted
    function automatic instr_t mem_word(input fetch_addr_t a);
        return {~a[31:16], a[15:0]};
    endfunction

    function automatic fetch_addr_t line_of(input fetch_addr_t a);
        return {a[31:`ICACHE_OFFSET_BITS], {`ICACHE_OFFSET_BITS{1'b0}}};
    endfunction

    task automatic check_instr(input instr_t got, input instr_t exp, input fetch_addr_t got_pc,
                               input fetch_addr_t exp_pc, input string what);
        checks++;
        if (got !== exp || got_pc !== exp_pc) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h at %h, expected %h at %h",
                     $time, what, got, got_pc, exp, exp_pc);
        end
    endtask

    task automatic check_exc(input fetch_exc_t got, input fetch_exc_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %s, expected %s",
                     $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_req_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    // request to ready after 0 to 3 cycles, then four beats with random gaps
    initial begin : memory_model
        int unsigned seed_draw;
        fetch_addr_t base;
        int          wait_cycles;
        seed_draw = $urandom(32'h9b383dda);
        mem_rdy   = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        forever begin
            @(negedge clk);
            if (mem_req && !reset) begin
                base        = mem_addr;
                wait_cycles = $urandom % 4;
                repeat (wait_cycles) @(negedge clk);
                mem_rdy = 1'b1;
                @(negedge clk);
                mem_rdy = 1'b0;
                for (int i = 0; i < 4; i++) begin
                    wait_cycles = $urandom % 3;
                    repeat (wait_cycles) @(negedge clk);
                    ret_valid = 1'b1;
                    ret_last  = (i == 3);
                    ret_data  = mem_word(base + fetch_addr_t'(4 * i));
                    @(negedge clk);
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (mem_req && mem_rdy) req_log.push_back(mem_addr);   // handshake cycle
    end

    always @(posedge clk) begin
        if (!reset) cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, the lanes stopped delivering", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic run_test(input int t);
        logic [31:0] do_redirect;
        fetch_addr_t target;
        fetch_addr_t exp_pc;
        fetch_addr_t lo;
        fetch_addr_t hi;
        logic        exc_expected;
        logic        odd;
        int          want;
        int          reqs_expected;
        int          got;
        int          reqs;
        int          first_req;
        int          errors_before;
        do_redirect   = stim[t*FIELDS];
        target        = stim[t*FIELDS + 1];
        want          = stim[t*FIELDS + 2];
        exc_expected  = stim[t*FIELDS + 3][0];
        reqs_expected = stim[t*FIELDS + 4];
        exp_pc        = target;
        lo            = line_of(target);
        hi            = line_of(target + fetch_addr_t'(4 * (want - 1)));
        got           = 0;
        reqs          = 0;
        errors_before = errors;
        first_req     = req_log.size();
        if (do_redirect[0]) begin
            redirect    = 1'b1;
            redirect_pc = target;
            @(negedge clk);
            redirect = 1'b0;   // lanes shown now come from before the redirect
        end
        while (got < want) begin
            @(negedge clk);
            if (lane1_valid && !lane0_valid) note_failure("lane 1 raised without lane 0");
            if (lane0_valid) begin
                odd = exp_pc[2];
                if (exc_expected) begin
                    check_exc(out_exc, EXC_MISALIGNED, "lane 0 exception");
                    check_instr(lane0_instr, '0, out_pc, exp_pc, "lane 0");
                    if (lane1_valid) note_failure("lane 1 raised on a misaligned fetch");
                end else begin
                    check_exc(out_exc, EXC_NONE, "lane 0 exception");
                    check_instr(lane0_instr, mem_word(exp_pc), out_pc, exp_pc, "lane 0");
                    if (lane1_valid && odd)
                        note_failure("lane 1 raised for a packet entered at its upper word");
                    if (!lane1_valid && !odd)
                        note_failure("lane 1 missing for a packet entered at its lower word");
                end
                got++;
                exp_pc += 32'd4;
                if (lane1_valid && got < want) begin
                    check_instr(lane1_instr, mem_word(exp_pc), out_pc + 32'd4, exp_pc, "lane 1");
                    got++;
                    exp_pc += 32'd4;
                end
            end
        end
        for (int i = first_req; i < req_log.size(); i++) begin
            if (req_log[i] >= lo && req_log[i] <= hi) reqs++;
        end
        check_req_count(reqs, reqs_expected, "memory requests for the target lines");
        $display("test %0d, target %h, %0d instructions: %s", t, target, want,
                 (errors == errors_before) ? "ok" : "failed");
    endtask

    initial begin : stimulus_run
        int total;
        reset       = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        checks      = 0;
        errors      = 0;
        cycles      = 0;
        num_tests   = 0;
        total       = 0;
        for (int i = 0; i < FIELDS * MAX_TESTS; i++) stim[i] = '1;   // end marker everywhere
        $readmemh("bench/fetch_stimulus.txt", stim);
        while (num_tests < MAX_TESTS && stim[num_tests*FIELDS] !== 32'hffff_ffff) begin
            total += stim[num_tests*FIELDS + 2];
            num_tests++;
        end
        limit = total * 40;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        if (num_tests == 0) note_failure("the stimulus file holds no tests");
        for (int t = 0; t < num_tests; t++) run_test(t);
        repeat (4) @(negedge clk);
        $display("%0d tests, %0d checks, %0d errors", num_tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- source/fetch_align.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

module fetch_align import fetch_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          epoch,
    input  logic          resp_valid,
    input  fetch_packet_t resp_data,
    input  fetch_addr_t   resp_pc,
    input  fetch_cookie_t resp_cookie,
    input  fetch_exc_t    resp_exc,
    output logic          lane0_valid,
    output instr_t        lane0_instr,
    output logic          lane1_valid,
    output instr_t        lane1_instr,
    output fetch_addr_t   out_pc,
    output fetch_exc_t    out_exc
);

    logic live;    // response from the current path
    logic upper;   // pc points at the second word of the packet

    assign live  = resp_valid & (resp_cookie[`FETCH_COOKIE_BITS-1] == epoch);
    assign upper = resp_pc[2];

    always_ff @(posedge clk) begin
        if (reset) begin
            lane0_valid <= 1'b0;
            lane1_valid <= 1'b0;
        end else begin
            lane0_valid <= live;
            lane1_valid <= live & ~upper & (resp_exc == EXC_NONE);
        end
    end

    always_ff @(posedge clk) begin
        if (live) begin
            lane0_instr <= upper ? resp_data[63:32] : resp_data[31:0];
            lane1_instr <= resp_data[63:32];
            out_pc      <= resp_pc;
            out_exc     <= resp_exc;
        end
    end

endmodule

//--- source/fetch_pc_gen.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

module fetch_pc_gen import fetch_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          ready,
    input  logic          redirect,
    input  fetch_addr_t   redirect_pc,
    output logic          req_valid,
    output fetch_addr_t   req_pc,
    output fetch_cookie_t req_cookie,
    output logic          epoch
);

    fetch_addr_t                   next_pc;
    logic                          epoch_q;
    logic [`FETCH_COOKIE_BITS-2:0] seq;
    logic                          running;   // set once reset is released

    // no request while the path changes, the next one goes to the target
    assign req_valid  = running & ready & ~redirect;
    assign req_pc     = next_pc;
    assign req_cookie = {epoch_q, seq};
    assign epoch      = epoch_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            next_pc <= `FETCH_RESET_PC;
            epoch_q <= 1'b0;
            seq     <= '0;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            if (redirect) begin
                next_pc <= redirect_pc;
                epoch_q <= ~epoch_q;              // older responses become stale
            end else if (req_valid) begin
                next_pc <= {next_pc[31:3], 3'b000} + 32'd8;   // next packet
                seq     <= seq + 1'b1;
            end
        end
    end

endmodule

//--- source/fetch_pkg.sv
`include "icache_settings.svh"

package fetch_pkg;

    typedef logic [31:0] fetch_addr_t;      // byte address
    typedef logic [`FETCH_COOKIE_BITS-1:0] fetch_cookie_t;
    typedef logic [63:0] fetch_packet_t;    // two instruction words
    typedef logic [31:0] instr_t;
    typedef logic [`ICACHE_LINE_BYTES*8-1:0] line_t;
    typedef logic way_t;

    // only misalignment is reported by this front end
    typedef enum logic [1:0] {
        EXC_NONE       = 2'd0,
        EXC_MISALIGNED = 2'd1,
        EXC_RESERVED   = 2'd2
    } fetch_exc_t;

endpackage

//--- source/fetch_top.sv
`timescale 1ns/1ns

module fetch_top import fetch_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        redirect,
    input  fetch_addr_t redirect_pc,
    output logic        mem_req,
    output fetch_addr_t mem_addr,
    input  logic        mem_rdy,
    input  logic        ret_valid,
    input  logic        ret_last,
    input  instr_t      ret_data,
    output logic        lane0_valid,
    output instr_t      lane0_instr,
    output logic        lane1_valid,
    output instr_t      lane1_instr,
    output fetch_addr_t out_pc,
    output fetch_exc_t  out_exc
);

    logic          req_valid;
    logic          ready;
    logic          epoch;
    fetch_addr_t   req_pc;
    fetch_cookie_t req_cookie;
    logic          resp_valid;
    fetch_packet_t resp_data;
    fetch_addr_t   resp_pc;
    fetch_cookie_t resp_cookie;
    fetch_exc_t    resp_exc;

    fetch_pc_gen u_pc_gen (
        .clk         (clk),
        .reset       (reset),
        .ready       (ready),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .req_valid   (req_valid),
        .req_pc      (req_pc),
        .req_cookie  (req_cookie),
        .epoch       (epoch)
    );

    icache u_icache (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req_pc      (req_pc),
        .req_cookie  (req_cookie),
        .ready       (ready),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_rdy     (mem_rdy),
        .ret_valid   (ret_valid),
        .ret_last    (ret_last),
        .ret_data    (ret_data),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .resp_pc     (resp_pc),
        .resp_cookie (resp_cookie),
        .resp_exc    (resp_exc)
    );

    fetch_align u_align (
        .clk         (clk),
        .reset       (reset),
        .epoch       (epoch),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .resp_pc     (resp_pc),
        .resp_cookie (resp_cookie),
        .resp_exc    (resp_exc),
        .lane0_valid (lane0_valid),
        .lane0_instr (lane0_instr),
        .lane1_valid (lane1_valid),
        .lane1_instr (lane1_instr),
        .out_pc      (out_pc),
        .out_exc     (out_exc)
    );

endmodule

//--- source/icache.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache import fetch_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          req_valid,
    input  fetch_addr_t   req_pc,
    input  fetch_cookie_t req_cookie,
    output logic          ready,
    output logic          mem_req,
    output fetch_addr_t   mem_addr,
    input  logic          mem_rdy,
    input  logic          ret_valid,
    input  logic          ret_last,
    input  instr_t        ret_data,
    output logic          resp_valid,
    output fetch_packet_t resp_data,
    output fetch_addr_t   resp_pc,
    output fetch_cookie_t resp_cookie,
    output fetch_exc_t    resp_exc
);

    fetch_addr_t   rbuf_pc;
    fetch_cookie_t rbuf_cookie;
    way_t          victim;
    way_t          victim_q;
    way_t          hit_way;
    logic          hit;
    logic          misaligned;
    logic          rbuf_we;
    logic          vbuf_we;
    logic          fill_we;
    logic          fill_finish;
    logic          replay;
    fetch_addr_t   rd_pc;
    line_t         fill_line;
    line_t         line_way0;
    line_t         line_way1;
    line_t         hit_line;
    fetch_packet_t half;

    // request and victim buffers
    always_ff @(posedge clk) begin
        if (rbuf_we) begin
            rbuf_pc     <= req_pc;
            rbuf_cookie <= req_cookie;
        end
        if (vbuf_we) victim_q <= victim;
    end

    assign rd_pc      = replay ? rbuf_pc : req_pc;
    assign misaligned = |rbuf_pc[1:0];
    assign mem_addr   = {rbuf_pc[31:`ICACHE_OFFSET_BITS], {`ICACHE_OFFSET_BITS{1'b0}}};

    assign hit_line  = hit_way ? line_way1 : line_way0;
    assign half      = rbuf_pc[3] ? hit_line[127:64] : hit_line[63:0];
    assign resp_data = misaligned ? '0 : half;
    assign resp_exc  = misaligned ? EXC_MISALIGNED : EXC_NONE;
    assign resp_pc     = rbuf_pc;
    assign resp_cookie = rbuf_cookie;

    icache_tagv u_tagv (
        .clk     (clk),
        .reset   (reset),
        .rd_pc   (rd_pc),
        .cmp_pc  (rbuf_pc),
        .we      (fill_we),
        .we_way  (victim_q),
        .hit     (hit),
        .hit_way (hit_way),
        .victim  (victim)
    );

    icache_data u_data (
        .clk       (clk),
        .rd_pc     (rd_pc),
        .wr_pc     (rbuf_pc),
        .we        (fill_we),
        .we_way    (victim_q),
        .line_in   (fill_line),
        .line_way0 (line_way0),
        .line_way1 (line_way1)
    );

    icache_refill u_refill (
        .clk         (clk),
        .reset       (reset),
        .ret_valid   (ret_valid),
        .ret_last    (ret_last),
        .ret_data    (ret_data),
        .line        (fill_line),
        .fill_finish (fill_finish)
    );

    icache_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .misaligned  (misaligned),
        .hit         (hit),
        .mem_rdy     (mem_rdy),
        .fill_finish (fill_finish),
        .rbuf_we     (rbuf_we),
        .vbuf_we     (vbuf_we),
        .mem_req     (mem_req),
        .fill_we     (fill_we),
        .replay      (replay),
        .resp_valid  (resp_valid),
        .ready       (ready)
    );

endmodule

//--- source/icache_ctrl.sv
`timescale 1ns/1ns

module icache_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic req_valid,
    input  logic misaligned,
    input  logic hit,
    input  logic mem_rdy,
    input  logic fill_finish,
    output logic rbuf_we,
    output logic vbuf_we,
    output logic mem_req,
    output logic fill_we,
    output logic replay,
    output logic resp_valid,
    output logic ready
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_REQUEST,
        S_WAIT_REFILL,
        S_REPLAY
    } state_t;

    state_t state;
    state_t state_next;
    logic   done;     // lookup finished without memory

    assign done = hit | misaligned;

    always_comb begin
        rbuf_we    = 1'b0;
        vbuf_we    = 1'b0;
        mem_req    = 1'b0;
        fill_we    = 1'b0;
        replay     = 1'b0;
        resp_valid = 1'b0;
        ready      = 1'b0;
        state_next = state;
        case (state)
            S_IDLE: begin
                ready = 1'b1;
            end
            S_LOOKUP: begin
                if (done) begin
                    resp_valid = 1'b1;
                    ready      = 1'b1;
                    state_next = S_IDLE;
                end else begin
                    vbuf_we    = 1'b1;          // victim for this set
                    mem_req    = 1'b1;          // request goes out right away
                    state_next = mem_rdy ? S_WAIT_REFILL : S_REQUEST;
                end
            end
            S_REQUEST: begin
                mem_req = 1'b1;
                if (mem_rdy) state_next = S_WAIT_REFILL;
            end
            S_WAIT_REFILL: begin
                if (fill_finish) begin
                    fill_we    = 1'b1;
                    replay     = 1'b1;          // reread the buffered address
                    state_next = S_REPLAY;
                end
            end
            S_REPLAY: begin
                resp_valid = 1'b1;
                ready      = 1'b1;
                state_next = S_IDLE;
            end
            default: state_next = S_IDLE;
        endcase
        // back to back requests on every ready cycle
        if (ready && req_valid) begin
            rbuf_we    = 1'b1;
            state_next = S_LOOKUP;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) state <= S_IDLE;
        else       state <= state_next;
    end

endmodule

//--- source/icache_data.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_data import fetch_pkg::*; (
    input  logic        clk,
    input  fetch_addr_t rd_pc,
    input  fetch_addr_t wr_pc,
    input  logic        we,
    input  way_t        we_way,
    input  line_t       line_in,
    output line_t       line_way0,
    output line_t       line_way1
);

    line_t                         mem0 [`ICACHE_SETS];
    line_t                         mem1 [`ICACHE_SETS];
    logic [`ICACHE_INDEX_BITS-1:0] rd_idx;
    logic [`ICACHE_INDEX_BITS-1:0] wr_idx;
    logic                          same_set;

    assign rd_idx   = rd_pc[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    assign wr_idx   = wr_pc[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    assign same_set = (rd_idx == wr_idx);

    // whole line per write, read data one cycle after the address
    always_ff @(posedge clk) begin
        if (we && !we_way) mem0[wr_idx] <= line_in;
        if (we && we_way)  mem1[wr_idx] <= line_in;

        if (we && !we_way && same_set) line_way0 <= line_in;   // write first
        else                           line_way0 <= mem0[rd_idx];

        if (we && we_way && same_set)  line_way1 <= line_in;
        else                           line_way1 <= mem1[rd_idx];
    end

endmodule

//--- source/icache_refill.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_refill import fetch_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   ret_valid,
    input  logic   ret_last,
    input  instr_t ret_data,
    output line_t  line,
    output logic   fill_finish
);

    logic [`ICACHE_BEAT_BITS-1:0] beat;   // next word slot in the line

    always_ff @(posedge clk) begin
        if (reset) begin
            beat        <= '0;
            fill_finish <= 1'b0;
        end else begin
            fill_finish <= ret_valid & ret_last;
            if (ret_valid) begin
                if (ret_last) beat <= '0;
                else          beat <= beat + 1'b1;
            end
        end
    end

    // lowest word arrives first
    always_ff @(posedge clk) begin
        if (ret_valid) line[{beat, 5'd0} +: 32] <= ret_data;
    end

endmodule

//--- source/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// cache geometry, fixed by the address split below
`define ICACHE_SETS         64
`define ICACHE_INDEX_BITS   6
`define ICACHE_LINE_BYTES   16
`define ICACHE_OFFSET_BITS  4
`define ICACHE_BEAT_BITS    2      // four 32-bit beats per line
`define ICACHE_TAG_BITS     22     // address bits above index and offset

// fetch side
`define FETCH_COOKIE_BITS   8      // epoch bit on top, sequence below
`define FETCH_RESET_PC      32'h0000_1000

`endif

//--- source/icache_tagv.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_tagv import fetch_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  fetch_addr_t rd_pc,
    input  fetch_addr_t cmp_pc,
    input  logic        we,
    input  way_t        we_way,
    output logic        hit,
    output way_t        hit_way,
    output way_t        victim
);

    logic [`ICACHE_TAG_BITS-1:0]   tag0 [`ICACHE_SETS];
    logic [`ICACHE_TAG_BITS-1:0]   tag1 [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0]       valid0;
    logic [`ICACHE_SETS-1:0]       valid1;
    logic [`ICACHE_SETS-1:0]       lru;          // the way to replace next
    logic [`ICACHE_INDEX_BITS-1:0] rd_idx;
    logic [`ICACHE_INDEX_BITS-1:0] cmp_idx;
    logic [`ICACHE_INDEX_BITS-1:0] rd_idx_q;
    logic [`ICACHE_TAG_BITS-1:0]   cmp_tag;
    logic [`ICACHE_TAG_BITS-1:0]   tag0_q;
    logic [`ICACHE_TAG_BITS-1:0]   tag1_q;
    logic                          val0_q;
    logic                          val1_q;
    logic                          fwd0;
    logic                          fwd1;
    logic                          hit0;
    logic                          hit1;

    assign rd_idx  = rd_pc[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    assign cmp_idx = cmp_pc[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    assign cmp_tag = cmp_pc[31 -: `ICACHE_TAG_BITS];

    // a fill read back in the same cycle sees the new entry
    assign fwd0 = we & ~we_way & (cmp_idx == rd_idx);
    assign fwd1 = we &  we_way & (cmp_idx == rd_idx);

    // read index must match too, otherwise the stored tags belong to another set
    assign hit0    = val0_q & (tag0_q == cmp_tag) & (rd_idx_q == cmp_idx);
    assign hit1    = val1_q & (tag1_q == cmp_tag) & (rd_idx_q == cmp_idx);
    assign hit     = hit0 | hit1;
    assign hit_way = hit1;
    assign victim  = lru[cmp_idx];

    always_ff @(posedge clk) begin
        if (we && !we_way) tag0[cmp_idx] <= cmp_tag;
        if (we && we_way)  tag1[cmp_idx] <= cmp_tag;
        tag0_q   <= fwd0 ? cmp_tag : tag0[rd_idx];
        tag1_q   <= fwd1 ? cmp_tag : tag1[rd_idx];
        rd_idx_q <= rd_idx;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid0 <= '0;
            valid1 <= '0;
            lru    <= '0;
            val0_q <= 1'b0;
            val1_q <= 1'b0;
        end else begin
            if (we) begin
                if (we_way) valid1[cmp_idx] <= 1'b1;
                else        valid0[cmp_idx] <= 1'b1;
                lru[cmp_idx] <= ~we_way;
            end else if (hit) begin
                lru[cmp_idx] <= ~hit_way;      // other way is now the older one
            end
            val0_q <= valid0[rd_idx] | fwd0;
            val1_q <= valid1[rd_idx] | fwd1;
        end
    end

endmodule

//--- src.f
+incdir+source
source/fetch_pkg.sv
source/fetch_pc_gen.sv
source/icache_tagv.sv
source/icache_data.sv
source/icache_refill.sv
source/icache_ctrl.sv
source/icache.sv
source/fetch_align.sv
source/fetch_top.sv
bench/fetch_tb.sv
